/* Makefile */
# Verilator build and run for the reservation station testbench

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing
TOP        := rs_tb
FILELIST   := project.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, a missing pass line fails the target
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* project.f */
rtl/rs_pkg.sv
rtl/rs_alloc.sv
rtl/rs_slot.sv
rtl/rs_issue_select.sv
rtl/rs_top.sv
test/rs_tb.sv

/* rtl/rs_alloc.sv */
//////////////////////////////////////////////////////////////////////
// Dispatch allocator for the reservation station
// Maps up to two dispatch requests onto free slots, combinational
// Also reports the number of free slots to the dispatch stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rs_alloc (
    input  logic [rs_pkg::DISPATCH_WIDTH-1:0]                   alloc_valid,
    input  rs_pkg::rs_entry_t [rs_pkg::DISPATCH_WIDTH-1:0]      alloc_entry,
    input  logic [rs_pkg::RS_SIZE-1:0]                          busy,
    output logic [rs_pkg::DISPATCH_WIDTH-1:0]                   dispatch_accept,
    output logic [rs_pkg::RS_SIZE-1:0]                          slot_write,
    output rs_pkg::rs_entry_t [rs_pkg::RS_SIZE-1:0]             slot_data,
    output rs_pkg::slot_count_t                                 free_slots
);

    import rs_pkg::*;

    logic [RS_SIZE-1:0] grant0;     // One-hot, lowest free slot
    logic [RS_SIZE-1:0] grant1;     // One-hot, next free slot
    logic               has_free0;  // At least one slot free
    logic               has_free1;  // At least two slots free
    logic [RS_SIZE-1:0] req1_slot;  // Where request 1 lands
    logic               req1_ok;
    slot_count_t        free_cnt;

    //////////////////////////////////////////////////////////////////
    // Priority encode the two lowest free slots
    //////////////////////////////////////////////////////////////////
    always_comb begin
        grant0    = '0;
        grant1    = '0;
        has_free0 = 1'b0;
        has_free1 = 1'b0;
        for (int i = 0; i < RS_SIZE; i++) begin
            if (!busy[i]) begin
                if (!has_free0) begin
                    grant0[i] = 1'b1;  // First hole
                    has_free0 = 1'b1;
                end else if (!has_free1) begin
                    grant1[i] = 1'b1;  // Second hole
                    has_free1 = 1'b1;
                end
            end
        end
    end

    // Request 1 moves down to the lowest hole when request 0 is idle
    assign req1_slot = alloc_valid[0] ? grant1 : grant0;
    assign req1_ok   = alloc_valid[0] ? has_free1 : has_free0;

    assign dispatch_accept[0] = alloc_valid[0] & has_free0;
    assign dispatch_accept[1] = alloc_valid[1] & req1_ok;

    //////////////////////////////////////////////////////////////////
    // Route accepted requests to their slots
    //////////////////////////////////////////////////////////////////
    always_comb begin
        slot_write = '0;
        if (dispatch_accept[0]) begin
            slot_write = slot_write | grant0;
        end
        if (dispatch_accept[1]) begin
            slot_write = slot_write | req1_slot;
        end
    end

    // Every slot sees request 0 unless request 1 owns it
    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            if (dispatch_accept[1] && req1_slot[i]) begin
                slot_data[i] = alloc_entry[1];
            end else begin
                slot_data[i] = alloc_entry[0];
            end
        end
    end

    //////////////////////////////////////////////////////////////////
    // Occupancy count, from the same busy vector as dispatch
    //////////////////////////////////////////////////////////////////
    always_comb begin
        free_cnt = '0;
        for (int i = 0; i < RS_SIZE; i++) begin
            if (!busy[i]) begin
                free_cnt = free_cnt + slot_count_t'(1);
            end
        end
    end

    assign free_slots = free_cnt;

endmodule

/* rtl/rs_issue_select.sv */
//////////////////////////////////////////////////////////////////////
// Issue selector for the reservation station
// Picks the lowest ready slot, frees it, and holds the pick in the
// issue register until the functional unit takes it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rs_issue_select (
    input  logic                                       clock,
    input  logic                                       rst_n,
    input  logic                                       flush,
    input  logic [rs_pkg::RS_SIZE-1:0]                 busy,
    input  rs_pkg::rs_entry_t [rs_pkg::RS_SIZE-1:0]    held_entry,
    input  logic                                       issue_ready,
    output logic [rs_pkg::RS_SIZE-1:0]                 slot_clear,
    output logic                                       issue_valid,
    output rs_pkg::rs_entry_t                          issue_entry
);

    import rs_pkg::*;

    logic [RS_SIZE-1:0] ready_vec;  // Busy with both operands ready
    slot_idx_t          sel_idx;
    logic               sel_found;
    logic               can_load;   // Issue register free this edge
    logic               valid_q;
    rs_entry_t          entry_q;

    //////////////////////////////////////////////////////////////////
    // Ready vector and lowest-index pick
    //////////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            ready_vec[i] = busy[i] & held_entry[i].src1_ready & held_entry[i].src2_ready;
        end
    end

    always_comb begin
        sel_idx   = '0;
        sel_found = 1'b0;
        for (int i = 0; i < RS_SIZE; i++) begin
            if (ready_vec[i] && !sel_found) begin
                sel_idx   = slot_idx_t'(i);
                sel_found = 1'b1;
            end
        end
    end

    // Empty register or consumer taking the current one
    assign can_load = !valid_q || issue_ready;

    // Free the picked slot at the edge it moves into the register
    always_comb begin
        slot_clear = '0;
        if (can_load && sel_found) begin
            slot_clear[sel_idx] = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////
    // Issue register
    //////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (can_load) begin
            valid_q <= sel_found;  // Bubble when nothing ready
        end
    end

    // Held under back-pressure
    always_ff @(posedge clock) begin
        if (can_load && sel_found) begin
            entry_q <= held_entry[sel_idx];
        end
    end

    assign issue_valid = valid_q;
    assign issue_entry = entry_q;

endmodule

/* rtl/rs_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared sizes and types for the reservation station scheduling core
// Import with rs_pkg::* inside a module body; use rs_pkg:: in headers
//////////////////////////////////////////////////////////////////////

package rs_pkg;

    //////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////
    localparam int RS_SIZE        = 8;   // Entry slots
    localparam int DISPATCH_WIDTH = 2;   // Instructions offered per cycle
    localparam int CDB_WIDTH      = 2;   // Result broadcast buses
    localparam int TAG_BITS       = 6;   // Renamed register tag
    localparam int ROB_BITS       = 5;   // Reorder buffer index
    localparam int OP_BITS        = 4;   // Functional unit opcode
    localparam int IMM_BITS       = 16;  // Immediate and second source word

    //////////////////////////////////////////////////////////////////
    // Basic types
    //////////////////////////////////////////////////////////////////
    typedef logic [TAG_BITS-1:0]          tag_t;
    typedef logic [$clog2(RS_SIZE)-1:0]   slot_idx_t;    // 0..7
    typedef logic [$clog2(RS_SIZE+1)-1:0] slot_count_t;  // 0..8

    // Register form of the second source, tag in the low bits
    typedef struct packed {
        logic [IMM_BITS-TAG_BITS-1:0] pad;  // Always zero
        tag_t                         tag;
    } src2_reg_t;

    // Second source word, meaning picked by the entry's use_imm bit
    typedef union packed {
        logic [IMM_BITS-1:0] imm;      // use_imm high
        src2_reg_t           reg_tag;  // use_imm low
    } src2_u;

    //////////////////////////////////////////////////////////////////
    // Entry and broadcast formats
    //////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [ROB_BITS-1:0] rob_idx;     // Owning ROB entry
        logic [OP_BITS-1:0]  fu_op;       // Functional unit opcode
        tag_t                dest_tag;    // Result tag
        tag_t                src1_tag;
        logic                src1_ready;
        logic                use_imm;     // src2 holds an immediate
        src2_u               src2;
        logic                src2_ready;
        logic [5:0]          pad;         // Zero, rounds entry to 46 bits
    } rs_entry_t;

    // One result bus broadcast
    typedef struct packed {
        logic valid;
        tag_t tag;
    } cdb_tag_t;

endpackage

/* rtl/rs_slot.sv */
//////////////////////////////////////////////////////////////////////
// One reservation station entry with tag wakeup
// Loaded by the allocator, woken by the result buses, freed by issue
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rs_slot (
    input  logic                                       clock,
    input  logic                                       rst_n,
    input  logic                                       flush,
    input  logic                                       write,
    input  rs_pkg::rs_entry_t                          write_entry,
    input  logic                                       clear,
    input  rs_pkg::cdb_tag_t [rs_pkg::CDB_WIDTH-1:0]   cdb,
    output logic                                       busy,
    output rs_pkg::rs_entry_t                          held_entry
);

    import rs_pkg::*;

    logic      busy_q;
    logic      busy_n;
    rs_entry_t entry_q;
    rs_entry_t entry_n;

    //////////////////////////////////////////////////////////////////
    // Next state and wakeup
    //////////////////////////////////////////////////////////////////
    always_comb begin
        entry_n = write ? write_entry : entry_q;  // New entry wins
        busy_n  = busy_q;
        if (write) begin
            busy_n = 1'b1;
        end else if (clear) begin
            busy_n = 1'b0;  // Picked by issue
        end

        // Immediate operand needs no producer
        if (entry_n.use_imm) begin
            entry_n.src2_ready = 1'b1;
        end

        // Compare next-state tags so a same-edge write is woken too
        for (int b = 0; b < CDB_WIDTH; b++) begin
            if (busy_n && cdb[b].valid) begin
                if (cdb[b].tag == entry_n.src1_tag) begin
                    entry_n.src1_ready = 1'b1;
                end
                // Union read as a tag only in register form
                if (!entry_n.use_imm && cdb[b].tag == entry_n.src2.reg_tag.tag) begin
                    entry_n.src2_ready = 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////
    // State
    //////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (flush) begin
            busy_q <= 1'b0;  // Mispredict empties the slot even on a write
        end else begin
            busy_q <= busy_n;
        end
    end

    // Entry payload with its woken ready bits
    always_ff @(posedge clock) begin
        entry_q <= entry_n;
    end

    assign busy       = busy_q;
    assign held_entry = entry_q;

endmodule

/* rtl/rs_top.sv */
//////////////////////////////////////////////////////////////////////
// Reservation station top level, eight entries
// Dispatch in, tag wakeup from two result buses, one issue per cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rs_top (
    input  logic                                            clock,
    input  logic                                            rst_n,
    input  logic                                            flush,
    input  logic [rs_pkg::DISPATCH_WIDTH-1:0]               alloc_valid,
    input  rs_pkg::rs_entry_t [rs_pkg::DISPATCH_WIDTH-1:0]  alloc_entry,
    input  rs_pkg::cdb_tag_t [rs_pkg::CDB_WIDTH-1:0]        cdb,
    input  logic                                            issue_ready,
    output logic [rs_pkg::DISPATCH_WIDTH-1:0]               dispatch_accept,
    output rs_pkg::slot_count_t                             free_slots,
    output logic                                            issue_valid,
    output rs_pkg::rs_entry_t                               issue_entry
);

    import rs_pkg::*;

    logic [RS_SIZE-1:0]      busy;        // Slot occupancy
    rs_entry_t [RS_SIZE-1:0] held_entry;  // Slot contents to selector
    logic [RS_SIZE-1:0]      slot_write;  // Allocator load strobes
    rs_entry_t [RS_SIZE-1:0] slot_data;   // Allocator routed entries
    logic [RS_SIZE-1:0]      slot_clear;  // Selector free strobes

    //////////////////////////////////////////////////////////////////
    // Dispatch side
    //////////////////////////////////////////////////////////////////
    rs_alloc u_alloc (
        .alloc_valid     (alloc_valid),
        .alloc_entry     (alloc_entry),
        .busy            (busy),
        .dispatch_accept (dispatch_accept),
        .slot_write      (slot_write),
        .slot_data       (slot_data),
        .free_slots      (free_slots)
    );

    //////////////////////////////////////////////////////////////////
    // Entry slots
    //////////////////////////////////////////////////////////////////
    generate
        for (genvar i = 0; i < RS_SIZE; i++) begin : slot_gen
            rs_slot u_slot (
                .clock       (clock),
                .rst_n       (rst_n),
                .flush       (flush),
                .write       (slot_write[i]),
                .write_entry (slot_data[i]),
                .clear       (slot_clear[i]),
                .cdb         (cdb),  // Every slot snoops both buses
                .busy        (busy[i]),
                .held_entry  (held_entry[i])
            );
        end
    endgenerate

    //////////////////////////////////////////////////////////////////
    // Issue side
    //////////////////////////////////////////////////////////////////
    rs_issue_select u_issue (
        .clock       (clock),
        .rst_n       (rst_n),
        .flush       (flush),
        .busy        (busy),
        .held_entry  (held_entry),
        .issue_ready (issue_ready),
        .slot_clear  (slot_clear),
        .issue_valid (issue_valid),
        .issue_entry (issue_entry)
    );

endmodule

/* test/rs_tb.sv */
//////////////////////////////////////////////////////////////////////
// Directed testbench for the reservation station top level
// Six test tasks drive dispatch, result buses, back-pressure and flush
// A consumer monitor checks issued entries against an expected queue
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rs_tb;

    import rs_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int WATCHDOG_CYCLES = 500;  // About five times the test length

    logic                           clock;
    logic                           rst_n;
    logic                           flush;
    logic [DISPATCH_WIDTH-1:0]      alloc_valid;
    rs_entry_t [DISPATCH_WIDTH-1:0] alloc_entry;
    cdb_tag_t [CDB_WIDTH-1:0]       cdb;
    logic                           issue_ready;
    logic [DISPATCH_WIDTH-1:0]      dispatch_accept;
    slot_count_t                    free_slots;
    logic                           issue_valid;
    rs_entry_t                      issue_entry;

    rs_entry_t   exp_q[$];               // Expected issue order
    logic [31:0] rand_state = 32'd57;
    int          errors     = 0;
    int          checks     = 0;

    rs_top uut (.*);

    //////////////////////////////////////////////////////////////////
    // Clock, watchdog and issue monitor
    //////////////////////////////////////////////////////////////////
    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, the run did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

    // An entry leaves at the rising edge after valid and ready
    initial begin
        rs_entry_t head;
        forever begin
            @(negedge clock);
            #1;
            if (rst_n && issue_valid && issue_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Unexpected issue of rob_idx %h at %0t", issue_entry.rob_idx, $time);
                end else begin
                    head = exp_q.pop_front();
                    check_entry("issue_entry", head, issue_entry);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////
    task automatic check_entry(input string name, input rs_entry_t exp, input rs_entry_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_accept(input logic [DISPATCH_WIDTH-1:0] exp);
        checks++;
        if (dispatch_accept !== exp) begin
            errors++;
            $display("** Error: dispatch_accept expected %h got %h at %0t",
                     exp, dispatch_accept, $time);
        end
    endtask

    task automatic check_count(input slot_count_t exp);
        checks++;
        if (free_slots !== exp) begin
            errors++;
            $display("** Error: free_slots expected %h got %h at %0t", exp, free_slots, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    //////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rand_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rand_state = x;
        return x;
    endfunction

    function automatic tag_t rand_tag();
        logic [31:0] r;
        r = xorshift();
        return r[TAG_BITS-1:0];
    endfunction

    // Random rob, opcode and dest around the caller's sources
    function automatic rs_entry_t make_entry(input tag_t s1_tag, input logic s1_rdy,
                                             input logic use_imm,
                                             input logic [IMM_BITS-1:0] src2_word,
                                             input logic s2_rdy);
        rs_entry_t   e;
        logic [31:0] r;
        r            = xorshift();
        e            = '0;
        e.rob_idx    = r[ROB_BITS-1:0];
        e.fu_op      = r[8:5];
        e.dest_tag   = r[14:9];
        e.src1_tag   = s1_tag;
        e.src1_ready = s1_rdy;
        e.use_imm    = use_imm;
        if (use_imm) begin
            e.src2.imm = src2_word;
        end else begin
            e.src2.reg_tag.pad = '0;
            e.src2.reg_tag.tag = src2_word[TAG_BITS-1:0];
        end
        e.src2_ready = s2_rdy;
        return e;
    endfunction

    function automatic rs_entry_t ready_entry();
        return make_entry(rand_tag(), 1'b1, 1'b0, {10'b0, rand_tag()}, 1'b1);
    endfunction

    // Issued form keeps every field and sets both ready bits
    function automatic rs_entry_t issued_form(input rs_entry_t e);
        e.src1_ready = 1'b1;
        e.src2_ready = 1'b1;
        return e;
    endfunction

    task automatic next_cycle();
        @(negedge clock);
    endtask

    task automatic drive_dispatch(input logic [1:0] valid, input rs_entry_t e0,
                                  input rs_entry_t e1);
        alloc_valid    = valid;
        alloc_entry[0] = e0;
        alloc_entry[1] = e1;
    endtask

    task automatic drive_cdb(input logic [1:0] valid, input tag_t t0, input tag_t t1);
        cdb[0].valid = valid[0];
        cdb[0].tag   = t0;
        cdb[1].valid = valid[1];
        cdb[1].tag   = t1;
    endtask

    // Wait until the monitor has seen every expected issue
    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit) begin
            @(negedge clock);
            #2;
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Expected issue missing after %0d cycles, %0d left", limit, exp_q.size());
            exp_q.delete();
        end
        @(negedge clock);  // Back on the drive point
    endtask

    //////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////
    task automatic test_dual_dispatch();
        rs_entry_t a;
        rs_entry_t b;
        a = ready_entry();
        b = ready_entry();
        drive_dispatch(2'b11, a, b);
        exp_q.push_back(issued_form(a));  // Slot 0 first
        exp_q.push_back(issued_form(b));
        #1;
        check_accept(2'b11);
        next_cycle();
        drive_dispatch(2'b00, a, b);
        #1;
        check_accept(2'b00);
        check_count(slot_count_t'(6));
        check_bit("issue_valid", 1'b0, issue_valid);
        next_cycle();
        #1;
        check_bit("issue_valid", 1'b1, issue_valid);  // Two cycles after dispatch
        wait_drain(10);
        check_count(slot_count_t'(RS_SIZE));
    endtask

    task automatic test_wakeup();
        rs_entry_t a;
        rs_entry_t b;
        rs_entry_t c;
        a = make_entry(6'h11, 1'b0, 1'b0, {10'b0, rand_tag()}, 1'b1);  // Waits on src1
        b = make_entry(rand_tag(), 1'b1, 1'b0, 16'h0012, 1'b0);        // Waits on src2
        c = make_entry(6'h13, 1'b0, 1'b0, {10'b0, rand_tag()}, 1'b1);
        drive_dispatch(2'b11, a, b);
        next_cycle();
        drive_dispatch(2'b00, a, b);
        repeat (4) begin
            #1;
            check_bit("issue_valid", 1'b0, issue_valid);
            next_cycle();
        end
        drive_cdb(2'b01, 6'h11, '0);
        exp_q.push_back(issued_form(a));
        next_cycle();
        drive_cdb(2'b00, '0, '0);
        wait_drain(10);
        drive_cdb(2'b10, '0, 6'h12);  // Second bus
        exp_q.push_back(issued_form(b));
        next_cycle();
        drive_cdb(2'b00, '0, '0);
        wait_drain(10);
        // Broadcast on the same edge as the write
        drive_dispatch(2'b01, c, c);
        drive_cdb(2'b01, 6'h13, '0);
        exp_q.push_back(issued_form(c));
        next_cycle();
        drive_dispatch(2'b00, c, c);
        drive_cdb(2'b00, '0, '0);
        #1;
        check_bit("issue_valid", 1'b0, issue_valid);
        next_cycle();
        #1;
        check_bit("issue_valid", 1'b1, issue_valid);
        wait_drain(10);
    endtask

    task automatic test_imm_decode();
        rs_entry_t   e;
        logic [31:0] r;
        r = xorshift();
        e = make_entry(6'h16, 1'b0, 1'b1, {r[9:0], 6'h15}, 1'b0);  // Low bits look like a tag
        drive_dispatch(2'b01, e, e);
        next_cycle();
        drive_dispatch(2'b00, e, e);
        drive_cdb(2'b10, '0, 6'h16);  // src1 producer comes first
        exp_q.push_back(issued_form(e));
        next_cycle();
        drive_cdb(2'b01, 6'h15, '0);  // Matches the immediate's low bits
        #1;
        check_bit("issue_valid", 1'b0, issue_valid);
        next_cycle();
        drive_cdb(2'b00, '0, '0);
        #1;
        check_bit("issue_valid", 1'b1, issue_valid);  // No wait on src2
        wait_drain(10);
    endtask

    task automatic test_fill();
        rs_entry_t e[RS_SIZE];
        rs_entry_t a;
        rs_entry_t b;
        for (int i = 0; i < RS_SIZE; i++) begin
            e[i] = make_entry(tag_t'(32'h20 + i), 1'b0, 1'b0, {10'b0, rand_tag()}, 1'b1);
        end
        for (int i = 0; i < RS_SIZE; i += 2) begin
            drive_dispatch(2'b11, e[i], e[i+1]);
            #1;
            check_accept(2'b11);
            next_cycle();
        end
        drive_dispatch(2'b11, e[0], e[1]);  // Station full
        #1;
        check_count('0);
        check_accept(2'b00);
        next_cycle();
        drive_dispatch(2'b00, e[0], e[1]);
        for (int i = 0; i < RS_SIZE; i += 2) begin
            drive_cdb(2'b11, e[i].src1_tag, e[i+1].src1_tag);
            exp_q.push_back(issued_form(e[i]));
            exp_q.push_back(issued_form(e[i+1]));
            next_cycle();
        end
        drive_cdb(2'b00, '0, '0);
        wait_drain(20);
        a = ready_entry();
        b = ready_entry();
        drive_dispatch(2'b11, a, b);
        exp_q.push_back(issued_form(a));
        exp_q.push_back(issued_form(b));
        #1;
        check_accept(2'b11);
        next_cycle();
        drive_dispatch(2'b00, a, b);
        wait_drain(10);
    endtask

    task automatic test_backpressure();
        rs_entry_t p[3];
        for (int i = 0; i < 3; i++) begin
            p[i] = ready_entry();
            exp_q.push_back(issued_form(p[i]));
        end
        issue_ready = 1'b0;
        drive_dispatch(2'b11, p[0], p[1]);
        next_cycle();
        drive_dispatch(2'b01, p[2], p[2]);
        next_cycle();
        drive_dispatch(2'b00, p[2], p[2]);
        for (int k = 0; k < 10; k++) begin
            #1;
            check_bit("issue_valid", 1'b1, issue_valid);
            check_entry("issue_entry", exp_q[0], issue_entry);  // Held head
            check_count(slot_count_t'(6));
            next_cycle();
        end
        issue_ready = 1'b1;
        wait_drain(10);
        check_count(slot_count_t'(RS_SIZE));
    endtask

    task automatic test_flush();
        rs_entry_t r;
        rs_entry_t w1;
        rs_entry_t w2;
        r  = ready_entry();
        w1 = make_entry(6'h30, 1'b0, 1'b0, {10'b0, rand_tag()}, 1'b1);
        w2 = make_entry(rand_tag(), 1'b1, 1'b0, 16'h0031, 1'b0);
        issue_ready = 1'b0;  // Keep r parked in the issue register
        drive_dispatch(2'b11, r, w1);
        next_cycle();
        drive_dispatch(2'b01, w2, w2);
        next_cycle();
        drive_dispatch(2'b00, w2, w2);
        #1;
        check_bit("issue_valid", 1'b1, issue_valid);
        check_count(slot_count_t'(6));
        next_cycle();
        flush = 1'b1;
        next_cycle();
        flush       = 1'b0;
        issue_ready = 1'b1;
        #1;
        check_bit("issue_valid", 1'b0, issue_valid);
        check_count(slot_count_t'(RS_SIZE));
        next_cycle();
        drive_cdb(2'b11, 6'h30, 6'h31);  // Tags of the flushed entries
        next_cycle();
        drive_cdb(2'b00, '0, '0);
        repeat (4) begin
            #1;
            check_bit("issue_valid", 1'b0, issue_valid);
            next_cycle();
        end
    endtask

    //////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////
    initial begin
        rst_n       = 1'b0;
        flush       = 1'b0;
        alloc_valid = '0;
        alloc_entry = '0;
        cdb         = '0;
        issue_ready = 1'b1;
        repeat (5) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        #1;
        check_bit("issue_valid", 1'b0, issue_valid);
        check_count(slot_count_t'(RS_SIZE));
        next_cycle();
        test_dual_dispatch();
        test_wakeup();
        test_imm_decode();
        test_fill();
        test_backpressure();
        test_flush();
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
